/* soc_pkg.sv */
package soc_pkg;

    // bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    // upper address byte of the peripheral pages, anything else is RAM
    localparam logic [7:0] PAGE_TIMER = 8'hF0;
    localparam logic [7:0] PAGE_PRNG  = 8'hF1;
    localparam logic [7:0] PAGE_LEDS  = 8'hFF;

    // master request, single beat
    typedef struct packed {
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } bus_req_t;

    // slave response
    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } bus_rsp_t;

    // slave picked by the page decoder
    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_TIMER,
        SEL_PRNG,
        SEL_LEDS
    } slave_sel_e;

    // timer register offsets
    typedef enum logic [1:0] {
        REG_RELOAD_LO = 2'd0,
        REG_RELOAD_HI = 2'd1,
        REG_CTRL      = 2'd2,
        REG_STATUS    = 2'd3
    } timer_reg_e;

endpackage

/* reset_gen.sv */
`timescale 1ns/1ps

module reset_gen #(
    parameter int RESET_CYCLES = 16
) (
    input  logic clk,
    input  logic rst_i,
    input  logic rst_req_i,
    output logic sys_rst_o
);

    localparam int CNT_W = (RESET_CYCLES > 0) ? $clog2(RESET_CYCLES + 1) : 1;

    logic [CNT_W-1:0] cnt;
    logic             rst_any;

    assign rst_any = rst_i | rst_req_i;

    // counter reloads while any reset source is active
    always_ff @(posedge clk) begin
        if (rst_any) begin
            cnt       <= CNT_W'(RESET_CYCLES);
            sys_rst_o <= 1'b1;
        end else begin
            sys_rst_o <= (cnt != '0);
            if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

/* bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder (
    input  soc_pkg::bus_req_t req_i,
    output logic              ram_stb_o,
    output logic              timer_stb_o,
    output logic              prng_stb_o,
    output logic              leds_stb_o,
    input  soc_pkg::bus_rsp_t ram_rsp_i,
    input  soc_pkg::bus_rsp_t timer_rsp_i,
    input  soc_pkg::bus_rsp_t prng_rsp_i,
    input  soc_pkg::bus_rsp_t leds_rsp_i,
    output soc_pkg::bus_rsp_t rsp_o
);

    soc_pkg::slave_sel_e sel;

    // page compare on the upper address byte
    always_comb begin
        case (req_i.adr[15:8])
            soc_pkg::PAGE_TIMER: sel = soc_pkg::SEL_TIMER;
            soc_pkg::PAGE_PRNG:  sel = soc_pkg::SEL_PRNG;
            soc_pkg::PAGE_LEDS:  sel = soc_pkg::SEL_LEDS;
            default:             sel = soc_pkg::SEL_RAM;
        endcase
    end

    // only the chosen slave sees the strobe
    always_comb begin
        ram_stb_o   = 1'b0;
        timer_stb_o = 1'b0;
        prng_stb_o  = 1'b0;
        leds_stb_o  = 1'b0;
        rsp_o       = ram_rsp_i;
        case (sel)
            soc_pkg::SEL_TIMER: begin
                timer_stb_o = req_i.stb;
                rsp_o       = timer_rsp_i;
            end
            soc_pkg::SEL_PRNG: begin
                prng_stb_o = req_i.stb;
                rsp_o      = prng_rsp_i;
            end
            soc_pkg::SEL_LEDS: begin
                leds_stb_o = req_i.stb;
                rsp_o      = leds_rsp_i;
            end
            default: begin
                ram_stb_o = req_i.stb;
                rsp_o     = ram_rsp_i;
            end
        endcase
    end

endmodule

/* bram_wb8.sv */
`timescale 1ns/1ps

module bram_wb8 #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              stb_i,
    input  soc_pkg::bus_req_t req_i,
    output soc_pkg::bus_rsp_t rsp_o
);

    logic [7:0]               mem [2**RAM_ADDR_BITS];
    logic [RAM_ADDR_BITS-1:0] idx;
    logic [7:0]               dat_q;
    logic                     ack_q;
    logic                     acc;

    // higher address bits alias within the page span
    assign idx = req_i.adr[RAM_ADDR_BITS-1:0];

    // one access per strobe, the ack cycle itself is not taken again
    assign acc = stb_i & ~ack_q;

    always_ff @(posedge clk) begin
        if (acc && req_i.we) begin
            mem[idx] <= req_i.dat;
        end
        if (acc) begin
            dat_q <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= acc;
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = dat_q;

endmodule

/* leds_wb8.sv */
`timescale 1ns/1ps

module leds_wb8 (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              stb_i,
    input  soc_pkg::bus_req_t req_i,
    output soc_pkg::bus_rsp_t rsp_o,
    output logic [7:0]        leds_o
);

    logic ack_q;
    logic acc;

    assign acc = stb_i & ~ack_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q  <= 1'b0;
            leds_o <= 8'h00;
        end else begin
            ack_q <= acc;
            if (acc && req_i.we) begin
                leds_o <= req_i.dat;
            end
        end
    end

    // readback straight from the output register
    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = leds_o;

endmodule

/* prng_wb8.sv */
`timescale 1ns/1ps

module prng_wb8 (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              stb_i,
    input  soc_pkg::bus_req_t req_i,
    output soc_pkg::bus_rsp_t rsp_o
);

    logic [15:0] state;
    logic [15:0] seed;
    logic [7:0]  dat_q;
    logic        ack_q;
    logic        acc;

    // galois step, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    assign acc = stb_i & ~ack_q;

    // seed write replaces one byte of the state
    assign seed = req_i.adr[0] ? {req_i.dat, state[7:0]} : {state[15:8], req_i.dat};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
            state <= 16'h0001;
        end else begin
            ack_q <= acc;
            if (acc && req_i.we) begin
                // all-zero state would lock up
                state <= (seed == 16'h0000) ? 16'h0001 : seed;
            end else if (acc && !req_i.adr[0]) begin
                state <= lfsr_step(state);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc) begin
            dat_q <= req_i.adr[0] ? state[15:8] : state[7:0];
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = dat_q;

endmodule

/* timer_regs.sv */
`timescale 1ns/1ps

module timer_regs (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              stb_i,
    input  soc_pkg::bus_req_t req_i,
    output soc_pkg::bus_rsp_t rsp_o,
    input  logic              tick_i,
    output logic [15:0]       reload_o,
    output logic              enable_o,
    output logic              irq_o
);

    soc_pkg::timer_reg_e sel;
    logic [1:0]          ctrl_q;
    logic                expired_q;
    logic [7:0]          rd_dat;
    logic [7:0]          dat_q;
    logic                ack_q;
    logic                acc;
    logic                wr;

    assign sel = soc_pkg::timer_reg_e'(req_i.adr[1:0]);
    assign acc = stb_i & ~ack_q;
    assign wr  = acc & req_i.we;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            reload_o <= 16'h0000;
            ctrl_q   <= 2'b00;
        end else if (wr) begin
            case (sel)
                soc_pkg::REG_RELOAD_LO: reload_o[7:0]  <= req_i.dat;
                soc_pkg::REG_RELOAD_HI: reload_o[15:8] <= req_i.dat;
                soc_pkg::REG_CTRL:      ctrl_q         <= req_i.dat[1:0];
                default: ;
            endcase
        end
    end

    // sticky expired, a new tick wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            expired_q <= 1'b0;
            irq_o     <= 1'b0;
        end else begin
            if (tick_i) begin
                expired_q <= 1'b1;
            end else if (wr && sel == soc_pkg::REG_STATUS && req_i.dat[0]) begin
                expired_q <= 1'b0;
            end
            irq_o <= expired_q & ctrl_q[1];
        end
    end

    always_comb begin
        case (sel)
            soc_pkg::REG_RELOAD_LO: rd_dat = reload_o[7:0];
            soc_pkg::REG_RELOAD_HI: rd_dat = reload_o[15:8];
            soc_pkg::REG_CTRL:      rd_dat = {6'b0, ctrl_q};
            default:                rd_dat = {7'b0, expired_q};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= acc;
        end
        if (acc) begin
            dat_q <= rd_dat;
        end
    end

    assign enable_o  = ctrl_q[0];
    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = dat_q;

endmodule

/* timer_core.sv */
`timescale 1ns/1ps

module timer_core #(
    parameter int TIMER_PRESCALE = 4
) (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        enable_i,
    input  logic [15:0] reload_i,
    output logic        tick_o
);

    localparam int PS_W = (TIMER_PRESCALE > 1) ? $clog2(TIMER_PRESCALE) : 1;

    logic [PS_W-1:0] ps_cnt;
    logic [15:0]     count;
    logic            step;

    // one decrement every TIMER_PRESCALE cycles
    assign step = (ps_cnt == PS_W'(TIMER_PRESCALE - 1));

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ps_cnt <= '0;
            count  <= reload_i;
            tick_o <= 1'b0;
        end else begin
            tick_o <= 1'b0;
            if (!enable_i) begin
                // idle, track the reload value
                ps_cnt <= '0;
                count  <= reload_i;
            end else if (step) begin
                ps_cnt <= '0;
                if (count == 16'h0000) begin
                    count  <= reload_i;
                    tick_o <= 1'b1;
                end else begin
                    count <= count - 1'b1;
                end
            end else begin
                ps_cnt <= ps_cnt + 1'b1;
            end
        end
    end

endmodule

/* soc_top.sv */
`timescale 1ns/1ps

module soc_top #(
    parameter int RESET_CYCLES   = 16,
    parameter int RAM_ADDR_BITS  = 10,
    parameter int TIMER_PRESCALE = 4
) (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              rst_req_i,
    input  soc_pkg::bus_req_t bus_req_i,
    output soc_pkg::bus_rsp_t bus_rsp_o,
    output logic              ready_o,
    output logic [7:0]        leds_o,
    output logic              irq_o
);

    logic              sys_rst;
    logic              ram_stb;
    logic              timer_stb;
    logic              prng_stb;
    logic              leds_stb;
    soc_pkg::bus_rsp_t ram_rsp;
    soc_pkg::bus_rsp_t timer_rsp;
    soc_pkg::bus_rsp_t prng_rsp;
    soc_pkg::bus_rsp_t leds_rsp;
    logic [15:0]       timer_reload;
    logic              timer_enable;
    logic              timer_tick;

    reset_gen #(
        .RESET_CYCLES(RESET_CYCLES)
    ) reset_gen0 (
        .clk       (clk),
        .rst_i     (rst_i),
        .rst_req_i (rst_req_i),
        .sys_rst_o (sys_rst)
    );

    assign ready_o = ~sys_rst;

    bus_decoder bus_decoder0 (
        .req_i       (bus_req_i),
        .ram_stb_o   (ram_stb),
        .timer_stb_o (timer_stb),
        .prng_stb_o  (prng_stb),
        .leds_stb_o  (leds_stb),
        .ram_rsp_i   (ram_rsp),
        .timer_rsp_i (timer_rsp),
        .prng_rsp_i  (prng_rsp),
        .leds_rsp_i  (leds_rsp),
        .rsp_o       (bus_rsp_o)
    );

    bram_wb8 #(
        .RAM_ADDR_BITS(RAM_ADDR_BITS)
    ) bram0 (
        .clk   (clk),
        .rst_i (sys_rst),
        .stb_i (ram_stb),
        .req_i (bus_req_i),
        .rsp_o (ram_rsp)
    );

    leds_wb8 leds0 (
        .clk    (clk),
        .rst_i  (sys_rst),
        .stb_i  (leds_stb),
        .req_i  (bus_req_i),
        .rsp_o  (leds_rsp),
        .leds_o (leds_o)
    );

    prng_wb8 prng0 (
        .clk   (clk),
        .rst_i (sys_rst),
        .stb_i (prng_stb),
        .req_i (bus_req_i),
        .rsp_o (prng_rsp)
    );

    // register block steers the counter beside it
    timer_regs timer_regs0 (
        .clk      (clk),
        .rst_i    (sys_rst),
        .stb_i    (timer_stb),
        .req_i    (bus_req_i),
        .rsp_o    (timer_rsp),
        .tick_i   (timer_tick),
        .reload_o (timer_reload),
        .enable_o (timer_enable),
        .irq_o    (irq_o)
    );

    timer_core #(
        .TIMER_PRESCALE(TIMER_PRESCALE)
    ) timer_core0 (
        .clk      (clk),
        .rst_i    (sys_rst),
        .enable_i (timer_enable),
        .reload_i (timer_reload),
        .tick_o   (timer_tick)
    );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter realtime PERIOD = 100.0
) (
    output logic clk_o
);

    // free running, first rising edge at half a period
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2.0) clk_o = ~clk_o;
    end

endmodule

/* soc_assert.sv */
`timescale 1ns/1ps

module soc_assert (
    input logic              clk,
    input logic              rst_i,
    input soc_pkg::bus_req_t bus_req_i,
    input soc_pkg::bus_rsp_t bus_rsp_i,
    input logic              ready_i,
    input logic [7:0]        leds_i,
    input logic              irq_i
);

    int fail_cnt = 0;

    // ack is a single-cycle pulse
    ack_pulse: assert property (@(posedge clk) disable iff (rst_i)
        bus_rsp_i.ack |=> !bus_rsp_i.ack)
        else begin
            $error("ack high on two consecutive cycles");
            fail_cnt++;
        end

    ack_after_stb: assert property (@(posedge clk) disable iff (rst_i)
        bus_rsp_i.ack |-> $past(bus_req_i.stb))
        else begin
            $error("ack without a strobe in the cycle before");
            fail_cnt++;
        end

    // slaves see the stretched reset one cycle after ready drops
    quiet_in_reset: assert property (@(posedge clk) disable iff (rst_i)
        (!ready_i && $past(!ready_i)) |-> (!irq_i && !bus_rsp_i.ack))
        else begin
            $error("irq or ack active while the fabric is in reset");
            fail_cnt++;
        end

    leds_by_write: assert property (@(posedge clk) disable iff (rst_i)
        (leds_i != $past(leds_i)) |->
            ($past(bus_req_i.stb && bus_req_i.we
                   && bus_req_i.adr[15:8] == soc_pkg::PAGE_LEDS)
             || $past(!ready_i)))
        else begin
            $error("leds changed without a strobed write to the led page");
            fail_cnt++;
        end

endmodule

bind soc_top soc_assert soc_assert0 (
    .clk       (clk),
    .rst_i     (rst_i),
    .bus_req_i (bus_req_i),
    .bus_rsp_i (bus_rsp_o),
    .ready_i   (ready_o),
    .leds_i    (leds_o),
    .irq_i     (irq_o)
);

/* tb_soc.sv */
`timescale 1ns/1ps

module tb_soc;

    localparam int RESET_CYCLES   = 16;
    localparam int RAM_ADDR_BITS  = 10;
    localparam int TIMER_PRESCALE = 4;

    localparam int N_RAM        = 24;
    localparam int N_PRNG       = 16;
    localparam int TIMER_RELOAD = 20;
    localparam int TIMER_BUDGET = (TIMER_RELOAD + 2) * TIMER_PRESCALE + 10;
    // bus accesses of leds 3, ram 2*N_RAM+3, prng about N_PRNG+12 and timer 12
    localparam int N_ACCESS   = 3 + 2 * N_RAM + 3 + N_PRNG + 12 + 12;
    localparam int MAX_CYCLES = 20 * (N_ACCESS + TIMER_BUDGET);

    localparam logic [15:0] LEDS_ADR = {soc_pkg::PAGE_LEDS, 8'h00};
    localparam logic [15:0] PRNG_LO  = {soc_pkg::PAGE_PRNG, 8'h00};
    localparam logic [15:0] PRNG_HI  = {soc_pkg::PAGE_PRNG, 8'h01};
    localparam logic [15:0] LOW_MASK = 16'((1 << RAM_ADDR_BITS) - 1);

    logic              clk;
    logic              rst_i;
    logic              rst_req;
    soc_pkg::bus_req_t bus_req;
    soc_pkg::bus_rsp_t bus_rsp;
    logic              ready;
    logic [7:0]        leds;
    logic              irq;

    integer      seed;
    int          cycle = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          pushed = 0;
    int          compared = 0;
    string       name_q[$];
    logic [15:0] got_q[$];
    logic [15:0] exp_q[$];
    logic [7:0]  ram_model [2**RAM_ADDR_BITS];
    logic [15:0] ram_written[$];
    logic [15:0] prng_model;

    tb_clk_gen clk_gen0 (
        .clk_o (clk)
    );

    soc_top #(
        .RESET_CYCLES   (RESET_CYCLES),
        .RAM_ADDR_BITS  (RAM_ADDR_BITS),
        .TIMER_PRESCALE (TIMER_PRESCALE)
    ) dut0 (
        .clk       (clk),
        .rst_i     (rst_i),
        .rst_req_i (rst_req),
        .bus_req_i (bus_req),
        .bus_rsp_o (bus_rsp),
        .ready_o   (ready),
        .leds_o    (leds),
        .irq_o     (irq)
    );

    // galois lfsr step with tap mask 16'hB400
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ ({16{s[0]}} & 16'hB400);
    endfunction

    // move peripheral pages into plain ram space
    function automatic logic [15:0] ram_addr(input logic [15:0] a);
        logic [15:0] r;
        r = a;
        if (a[15:8] == soc_pkg::PAGE_TIMER || a[15:8] == soc_pkg::PAGE_PRNG
                || a[15:8] == soc_pkg::PAGE_LEDS) begin
            r[15] = 1'b0;
        end
        return r;
    endfunction

    function automatic logic [15:0] timer_addr(input soc_pkg::timer_reg_e r);
        return {soc_pkg::PAGE_TIMER, 6'b0, r};
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("failure at cycle %0d: %s", cycle, msg);
        other_errors++;
    endtask

    task automatic report_counts();
        $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errors, other_errors, dut0.soc_assert0.fail_cnt);
    endtask

    // queued for the comparison process
    task automatic expect_value(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        name_q.push_back(name);
        got_q.push_back(got);
        exp_q.push_back(exp);
        pushed++;
    endtask

    task automatic bus_access(input logic we, input logic [15:0] adr,
                              input logic [7:0] wdat, output logic [7:0] rdat);
        soc_pkg::bus_req_t req;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        req.dat = wdat;
        @(posedge clk);
        bus_req <= req;
        // hold the request until the slave acknowledges
        do begin
            @(posedge clk);
        end while (!bus_rsp.ack);
        rdat = bus_rsp.dat;
        bus_req.stb <= 1'b0;
    endtask

    task automatic bus_write(input logic [15:0] adr, input logic [7:0] dat);
        logic [7:0] discard;
        bus_access(1'b1, adr, dat, discard);
    endtask

    task automatic bus_read(input logic [15:0] adr, output logic [7:0] dat);
        bus_access(1'b0, adr, 8'h00, dat);
    endtask

    // called on the edge that releases the reset source
    task automatic measure_reset_stretch(input string source);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (ready !== 1'b1);
        if (n - 1 < RESET_CYCLES) begin
            report_failure($sformatf("ready_o rose %0d cycles after %s fell", n - 1, source));
        end
    endtask

    // each seed byte write replaces one byte and a zero state becomes 1
    task automatic prng_seed(input logic [15:0] s);
        bus_write(PRNG_LO, s[7:0]);
        prng_model = {prng_model[15:8], s[7:0]};
        if (prng_model == 16'h0000) begin
            prng_model = 16'h0001;
        end
        bus_write(PRNG_HI, s[15:8]);
        prng_model = {s[15:8], prng_model[7:0]};
        if (prng_model == 16'h0000) begin
            prng_model = 16'h0001;
        end
    endtask

    // comparison process
    always @(posedge clk) begin
        while (name_q.size() > 0) begin
            check_value(name_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
            compared++;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            report_failure($sformatf("run did not finish within %0d cycles", MAX_CYCLES));
            report_counts();
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        logic [7:0]  rd;
        logic [7:0]  wd;
        logic [15:0] adr;
        int          k;
        int          t0;
        bit          done;

        seed       = 32'h73cf856d;
        rst_i      = 1'b1;
        rst_req    = 1'b0;
        bus_req    = '0;
        prng_model = 16'h0001;
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;
        measure_reset_stretch("rst_i");

        // nonzero led value so the reset clear shows
        wd = 8'($random(seed)) | 8'h01;
        bus_write(LEDS_ADR, wd);
        expect_value("leds_o", leds, wd);
        bus_read(LEDS_ADR, rd);
        expect_value("bus_rsp_o.dat (leds)", rd, wd);

        @(posedge clk);
        rst_req <= 1'b1;
        @(posedge clk);
        rst_req <= 1'b0;
        measure_reset_stretch("rst_req_i");
        expect_value("leds_o", leds, 8'h00);
        bus_read(LEDS_ADR, rd);
        expect_value("bus_rsp_o.dat (leds)", rd, 8'h00);

        for (int i = 0; i < N_RAM; i++) begin
            adr = ram_addr(16'($random(seed)));
            wd  = 8'($random(seed));
            bus_write(adr, wd);
            ram_model[adr[RAM_ADDR_BITS-1:0]] = wd;
            ram_written.push_back(adr);
        end
        // read back in random order through random aliases
        while (ram_written.size() > 0) begin
            k   = $unsigned($random(seed)) % ram_written.size();
            adr = ram_written[k];
            ram_written.delete(k);
            adr = ram_addr((16'($random(seed)) & ~LOW_MASK) | (adr & LOW_MASK));
            bus_read(adr, rd);
            expect_value("bus_rsp_o.dat (ram)", rd, ram_model[adr[RAM_ADDR_BITS-1:0]]);
        end
        bus_write(16'h0123, 8'h3C);
        bus_write(16'h0123 + 16'(1 << RAM_ADDR_BITS), 8'hC3);
        bus_read(16'h0123, rd);
        expect_value("bus_rsp_o.dat (ram alias)", rd, 8'hC3);

        prng_seed(16'($random(seed)));
        for (int i = 0; i < N_PRNG; i++) begin
            // high byte reads leave the state alone
            if (i % 5 == 4) begin
                bus_read(PRNG_HI, rd);
                expect_value("bus_rsp_o.dat (prng hi)", rd, prng_model[15:8]);
            end
            bus_read(PRNG_LO, rd);
            expect_value("bus_rsp_o.dat (prng lo)", rd, prng_model[7:0]);
            prng_model = lfsr_next(prng_model);
        end
        prng_seed(16'h0000);
        for (int i = 0; i < 4; i++) begin
            bus_read(PRNG_LO, rd);
            expect_value("bus_rsp_o.dat (prng zero seed)", rd, prng_model[7:0]);
            prng_model = lfsr_next(prng_model);
        end

        // timer with interrupt enabled
        bus_write(timer_addr(soc_pkg::REG_RELOAD_LO), 8'(TIMER_RELOAD));
        bus_write(timer_addr(soc_pkg::REG_RELOAD_HI), 8'(TIMER_RELOAD >> 8));
        bus_write(timer_addr(soc_pkg::REG_CTRL), 8'h03);
        t0 = cycle;
        bus_read(timer_addr(soc_pkg::REG_STATUS), rd);
        expect_value("bus_rsp_o.dat (timer status early)", rd, 8'h00);
        expect_value("irq_o", irq, 1'b0);
        done = 1'b0;
        while (!done) begin
            bus_read(timer_addr(soc_pkg::REG_STATUS), rd);
            if (rd[0]) begin
                if (cycle - t0 < TIMER_RELOAD * TIMER_PRESCALE) begin
                    report_failure("timer expired bit set before the reload period");
                end
                done = 1'b1;
            end else if (cycle - t0 > TIMER_BUDGET) begin
                report_failure("timer expired bit not set within the reload period");
                done = 1'b1;
            end
        end
        expect_value("irq_o", irq, 1'b1);

        // irq follows interrupt enable
        bus_write(timer_addr(soc_pkg::REG_CTRL), 8'h01);
        bus_read(timer_addr(soc_pkg::REG_STATUS), rd);
        expect_value("bus_rsp_o.dat (timer status)", rd, 8'h01);
        expect_value("irq_o", irq, 1'b0);
        bus_write(timer_addr(soc_pkg::REG_CTRL), 8'h03);
        bus_read(timer_addr(soc_pkg::REG_STATUS), rd);
        expect_value("bus_rsp_o.dat (timer status)", rd, 8'h01);
        expect_value("irq_o", irq, 1'b1);

        // write one to clear
        bus_write(timer_addr(soc_pkg::REG_STATUS), 8'h01);
        bus_read(timer_addr(soc_pkg::REG_STATUS), rd);
        expect_value("bus_rsp_o.dat (timer status cleared)", rd, 8'h00);
        expect_value("irq_o", irq, 1'b0);
        bus_write(timer_addr(soc_pkg::REG_CTRL), 8'h00);

        wait (compared == pushed);
        @(posedge clk);
        report_counts();
        if (value_errors == 0 && other_errors == 0 && dut0.soc_assert0.fail_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* flist.f */
soc_pkg.sv
reset_gen.sv
bus_decoder.sv
bram_wb8.sv
leds_wb8.sv
prng_wb8.sv
timer_regs.sv
timer_core.sv
soc_top.sv
tb_clk_gen.sv
soc_assert.sv
tb_soc.sv

/* Bender.yml */
package:
  name: soc_periph

sources:
  - files:
      - soc_pkg.sv
      - reset_gen.sv
      - bus_decoder.sv
      - bram_wb8.sv
      - leds_wb8.sv
      - prng_wb8.sv
      - timer_regs.sv
      - timer_core.sv
      - soc_top.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - soc_assert.sv
      - tb_soc.sv
